/* design/gs_config.svh */
/*
  gather-scatter engine configuration
  widths, memory depth, tag count and host address map
*/
`ifndef GS_CONFIG_SVH
`define GS_CONFIG_SVH

`define GS_DATA_W       32
`define GS_ADDR_W       32
`define GS_HOST_ADDR_W  12
`define GS_DMEM_WORDS   1024
`define GS_DMEM_ADDR_W  10
`define GS_LEN_W        11
`define GS_TAG_W        5
`define GS_TAGS         32
`define GS_WAKE_W       18

// host word map
`define GS_DMEM_BASE    12'h400
`define GS_INVALID_WORD 32'hdeadbeef
`define GS_CSR_RUN      12'h000
`define GS_CSR_LEN      12'h001
`define GS_CSR_STRIDE   12'h002
`define GS_CSR_BASE     12'h003

`endif

/* design/gs_pkg.sv */
/*
  gather-scatter engine package
  vector types for the meaningful widths and the sequencer states
*/
`include "gs_config.svh"

package gs_pkg;

  typedef logic [`GS_DATA_W-1:0]      data_t;
  typedef logic [`GS_ADDR_W-1:0]      raddr_t;
  typedef logic [`GS_HOST_ADDR_W-1:0] haddr_t;
  typedef logic [`GS_DMEM_ADDR_W-1:0] dmem_addr_t;
  typedef logic [`GS_LEN_W-1:0]       len_t;
  typedef logic [`GS_TAG_W-1:0]       tag_t;
  typedef logic [`GS_WAKE_W-1:0]      wake_addr_t;

  // run sequencing
  typedef enum logic [1:0] {
    IDLE,
    GATHER,
    SCATTER,
    WAKEUP
  } gs_state_e;

endpackage

/* design/gs_if.sv */
/*
  gather-scatter internal channels
  gs_mem_if is one DMEM access port, gs_run_if carries the run setup
*/

interface gs_mem_if;
  import gs_pkg::*;

  logic       v;
  logic       we;
  dmem_addr_t addr;
  data_t      wdata;
  // grant in the same cycle, read word from the next one
  logic       gnt;
  data_t      rdata;

  modport requester (output v, we, addr, wdata, input gnt, rdata);
  modport memory (input v, we, addr, wdata, output gnt, rdata);
endinterface

interface gs_run_if;
  import gs_pkg::*;

  logic       run;
  logic       scatter;
  len_t       len;
  raddr_t     stride;
  raddr_t     base;
  wake_addr_t wake_addr;
  logic       busy;

  modport host (
    output run, scatter, len, stride, base, wake_addr,
    input  busy
  );
  modport engine (
    input  run, scatter, len, stride, base, wake_addr,
    output busy
  );
endinterface

/* design/gs_host_port.sv */
/*
  gather-scatter host port
  decodes word commands, holds the run setup and answers each
  command exactly one cycle later
*/
`include "gs_config.svh"

module gs_host_port (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           cmd_v_i,
  input  logic           cmd_we_i,
  input  gs_pkg::haddr_t cmd_addr_i,
  input  gs_pkg::data_t  cmd_data_i,
  output logic           rsp_v_o,
  output gs_pkg::data_t  rsp_data_o,
  gs_run_if.host         run,
  gs_mem_if.requester    mem
);
  import gs_pkg::*;

  logic       is_dmem;
  logic       cfg_we;
  len_t       len_q;
  raddr_t     stride_q;
  raddr_t     base_q;
  wake_addr_t wake_q;
  logic       rsp_v_q;
  logic       rsp_dmem_q;
  logic       rsp_inv_q;

  assign is_dmem = (cmd_addr_i & ~haddr_t'(`GS_DMEM_WORDS - 1)) == `GS_DMEM_BASE;

  // nothing takes effect while a run is active
  assign cfg_we = cmd_v_i & cmd_we_i & ~run.busy;

  assign mem.v     = cmd_v_i & is_dmem & ~run.busy;
  assign mem.we    = cmd_we_i;
  assign mem.addr  = dmem_addr_t'(cmd_addr_i);
  assign mem.wdata = cmd_data_i;

  // run strobe, mode bit goes straight to the sequencer
  assign run.run       = cfg_we & (cmd_addr_i == `GS_CSR_RUN);
  assign run.scatter   = cmd_data_i[`GS_DATA_W-1];
  assign run.len       = len_q;
  assign run.stride    = stride_q;
  assign run.base      = base_q;
  assign run.wake_addr = wake_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      len_q <= '0;
    end else if (cfg_we && cmd_addr_i == `GS_CSR_LEN) begin
      len_q <= cmd_data_i[`GS_LEN_W-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (cfg_we && cmd_addr_i == `GS_CSR_STRIDE) begin
      stride_q <= cmd_data_i;
    end
    if (cfg_we && cmd_addr_i == `GS_CSR_BASE) begin
      base_q <= cmd_data_i;
    end
    if (run.run) begin
      wake_q <= cmd_data_i[`GS_WAKE_W-1:0];
    end
  end

  // response kind, writes answer zero
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_v_q    <= 1'b0;
      rsp_dmem_q <= 1'b0;
      rsp_inv_q  <= 1'b0;
    end else begin
      rsp_v_q    <= cmd_v_i;
      rsp_dmem_q <= cmd_v_i & ~cmd_we_i & mem.gnt;
      rsp_inv_q  <= cmd_v_i & ~cmd_we_i & ~mem.gnt;
    end
  end

  assign rsp_v_o = rsp_v_q;

  always_comb begin
    if (rsp_dmem_q) begin
      rsp_data_o = mem.rdata;
    end else if (rsp_inv_q) begin
      rsp_data_o = `GS_INVALID_WORD;
    end else begin
      rsp_data_o = '0;
    end
  end

endmodule

/* design/gs_sequencer.sv */
/*
  gather-scatter sequencer
  walks the element index, forms remote addresses and drives the
  network request port, ending each run with the wake-up store
*/

module gs_sequencer (
  input  logic               clk_i,
  input  logic               reset_i,
  gs_run_if.engine           run,
  gs_mem_if.requester        mem,
  input  logic               free_v_i,
  input  gs_pkg::tag_t       free_tag_i,
  output logic               alloc_o,
  output gs_pkg::dmem_addr_t alloc_index_o,
  input  logic               empty_i,
  output logic               req_v_o,
  input  logic               req_ready_i,
  output logic               req_we_o,
  output gs_pkg::raddr_t     req_addr_o,
  output gs_pkg::data_t      req_data_o,
  output gs_pkg::tag_t       req_tag_o
);
  import gs_pkg::*;

  gs_state_e state_q;
  gs_state_e state_n;
  len_t      idx_q;
  raddr_t    addr_q;
  logic      have_q;
  logic      accept;
  logic      idx_done;

  assign idx_done = (idx_q == run.len);
  assign accept   = req_v_o & req_ready_i;
  assign run.busy = (state_q != IDLE);

  // scatter fetches word i whenever no word is waiting
  assign mem.v     = (state_q == SCATTER) & ~have_q & ~idx_done;
  assign mem.we    = 1'b0;
  assign mem.addr  = dmem_addr_t'(idx_q);
  assign mem.wdata = '0;

  assign alloc_o       = accept & (state_q == GATHER);
  assign alloc_index_o = dmem_addr_t'(idx_q);

  always_comb begin
    state_n    = state_q;
    req_v_o    = 1'b0;
    req_we_o   = 1'b0;
    req_addr_o = addr_q;
    req_data_o = '0;
    req_tag_o  = '0;
    case (state_q)
      IDLE: begin
        if (run.run) begin
          if (run.len == '0) begin
            state_n = WAKEUP;
          end else begin
            state_n = run.scatter ? SCATTER : GATHER;
          end
        end
      end
      GATHER: begin
        // free tag holds until it is allocated
        req_v_o   = free_v_i & ~idx_done;
        req_tag_o = free_tag_i;
        if (idx_done) begin
          state_n = WAKEUP;
        end
      end
      SCATTER: begin
        req_v_o    = have_q;
        req_we_o   = 1'b1;
        req_data_o = mem.rdata;
        if (idx_done) begin
          state_n = WAKEUP;
        end
      end
      WAKEUP: begin
        // wait for every gather return before waking the caller
        req_v_o    = empty_i;
        req_we_o   = 1'b1;
        req_addr_o = raddr_t'(run.wake_addr);
        req_data_o = data_t'(1);
        if (accept) begin
          state_n = IDLE;
        end
      end
      default: state_n = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      idx_q   <= '0;
      have_q  <= 1'b0;
    end else begin
      state_q <= state_n;
      if (run.run) begin
        idx_q <= '0;
      end else if (accept && state_q != WAKEUP) begin
        idx_q <= idx_q + 1'b1;
      end
      if (accept) begin
        have_q <= 1'b0;
      end else if (mem.v && mem.gnt) begin
        have_q <= 1'b1;
      end
    end
  end

  // running remote address, base + i * stride
  always_ff @(posedge clk_i) begin
    if (run.run) begin
      addr_q <= run.base;
    end else if (accept) begin
      addr_q <= addr_q + run.stride;
    end
  end

endmodule

/* design/gs_scoreboard.sv */
/*
  gather tag scoreboard
  tracks outstanding remote reads and writes each return into
  the DMEM word its tag was issued for
*/
`include "gs_config.svh"

module gs_scoreboard (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               alloc_i,
  input  gs_pkg::dmem_addr_t alloc_index_i,
  output logic               free_v_o,
  output gs_pkg::tag_t       free_tag_o,
  output logic               empty_o,
  input  logic               ret_v_i,
  input  gs_pkg::tag_t       ret_tag_i,
  input  gs_pkg::data_t      ret_data_i,
  gs_mem_if.requester        mem
);
  import gs_pkg::*;

  logic [`GS_TAGS-1:0] out_q;
  logic [`GS_TAGS-1:0] out_n;
  dmem_addr_t          index_q [`GS_TAGS];
  logic                free_v_q;
  tag_t                free_tag_q;
  logic                found;
  tag_t                tag_n;

  // returns go to DMEM at once, highest priority
  assign mem.v     = ret_v_i;
  assign mem.we    = 1'b1;
  assign mem.addr  = index_q[ret_tag_i];
  assign mem.wdata = ret_data_i;

  always_comb begin
    out_n = out_q;
    if (ret_v_i) begin
      out_n[ret_tag_i] = 1'b0;
    end
    if (alloc_i) begin
      out_n[free_tag_q] = 1'b1;
    end
    // lowest clear bit wins
    found = 1'b0;
    tag_n = '0;
    for (int t = `GS_TAGS - 1; t >= 0; t--) begin
      if (!out_n[t]) begin
        found = 1'b1;
        tag_n = tag_t'(t);
      end
    end
  end

  // offered tag stays fixed until the sequencer takes it
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_q      <= '0;
      free_v_q   <= 1'b0;
      free_tag_q <= '0;
    end else begin
      out_q <= out_n;
      if (alloc_i || !free_v_q) begin
        free_v_q   <= found;
        free_tag_q <= tag_n;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      index_q[free_tag_q] <= alloc_index_i;
    end
  end

  assign free_v_o   = free_v_q;
  assign free_tag_o = free_tag_q;
  assign empty_o    = ~|out_q;

endmodule

/* design/gs_dmem.sv */
/*
  gather-scatter data memory
  single-port word array behind a fixed-priority arbiter,
  writeback first, then sequencer, then host
*/
`include "gs_config.svh"

module gs_dmem (
  input  logic     clk_i,
  gs_mem_if.memory wb,
  gs_mem_if.memory seq,
  gs_mem_if.memory host
);
  import gs_pkg::*;

  data_t      mem_q [`GS_DMEM_WORDS];
  data_t      rd_q;
  logic       acc_v;
  logic       acc_we;
  dmem_addr_t acc_addr;
  data_t      acc_wdata;

  assign wb.gnt   = wb.v;
  assign seq.gnt  = seq.v & ~wb.v;
  assign host.gnt = host.v & ~wb.v & ~seq.v;

  always_comb begin
    acc_v = wb.v | seq.v | host.v;
    if (wb.v) begin
      acc_we    = wb.we;
      acc_addr  = wb.addr;
      acc_wdata = wb.wdata;
    end else if (seq.v) begin
      acc_we    = seq.we;
      acc_addr  = seq.addr;
      acc_wdata = seq.wdata;
    end else begin
      acc_we    = host.we;
      acc_addr  = host.addr;
      acc_wdata = host.wdata;
    end
  end

  // read word is kept until the next read
  always_ff @(posedge clk_i) begin
    if (acc_v) begin
      if (acc_we) begin
        mem_q[acc_addr] <= acc_wdata;
      end else begin
        rd_q <= mem_q[acc_addr];
      end
    end
  end

  assign wb.rdata   = rd_q;
  assign seq.rdata  = rd_q;
  assign host.rdata = rd_q;

endmodule

/* design/gs_top.sv */
/*
  gather-scatter engine top
  host port, sequencer and scoreboard sharing one DMEM
*/

module gs_top (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           cmd_v_i,
  input  logic           cmd_we_i,
  input  gs_pkg::haddr_t cmd_addr_i,
  input  gs_pkg::data_t  cmd_data_i,
  output logic           rsp_v_o,
  output gs_pkg::data_t  rsp_data_o,
  output logic           req_v_o,
  input  logic           req_ready_i,
  output logic           req_we_o,
  output gs_pkg::raddr_t req_addr_o,
  output gs_pkg::data_t  req_data_o,
  output gs_pkg::tag_t   req_tag_o,
  input  logic           ret_v_i,
  input  gs_pkg::tag_t   ret_tag_i,
  input  gs_pkg::data_t  ret_data_i,
  output logic           busy_o
);
  import gs_pkg::*;

  logic       free_v;
  tag_t       free_tag;
  logic       alloc;
  dmem_addr_t alloc_index;
  logic       empty;

  gs_mem_if host_mem ();
  gs_mem_if seq_mem ();
  gs_mem_if wb_mem ();
  gs_run_if run_bus ();

  gs_host_port host_port (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .cmd_v_i    (cmd_v_i),
    .cmd_we_i   (cmd_we_i),
    .cmd_addr_i (cmd_addr_i),
    .cmd_data_i (cmd_data_i),
    .rsp_v_o    (rsp_v_o),
    .rsp_data_o (rsp_data_o),
    .run        (run_bus.host),
    .mem        (host_mem.requester)
  );

  gs_sequencer sequencer (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .run           (run_bus.engine),
    .mem           (seq_mem.requester),
    .free_v_i      (free_v),
    .free_tag_i    (free_tag),
    .alloc_o       (alloc),
    .alloc_index_o (alloc_index),
    .empty_i       (empty),
    .req_v_o       (req_v_o),
    .req_ready_i   (req_ready_i),
    .req_we_o      (req_we_o),
    .req_addr_o    (req_addr_o),
    .req_data_o    (req_data_o),
    .req_tag_o     (req_tag_o)
  );

  gs_scoreboard scoreboard (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .alloc_i       (alloc),
    .alloc_index_i (alloc_index),
    .free_v_o      (free_v),
    .free_tag_o    (free_tag),
    .empty_o       (empty),
    .ret_v_i       (ret_v_i),
    .ret_tag_i     (ret_tag_i),
    .ret_data_i    (ret_data_i),
    .mem           (wb_mem.requester)
  );

  gs_dmem dmem (
    .clk_i (clk_i),
    .wb    (wb_mem.memory),
    .seq   (seq_mem.memory),
    .host  (host_mem.memory)
  );

  assign busy_o = run_bus.busy;

endmodule

/* tests/gs_checker.sv */
/*
  gather-scatter protocol checker
  bound to the engine top, watches the request handshake,
  host response timing and the end of each run
*/

module gs_checker (
  input logic           clk_i,
  input logic           reset_i,
  input logic           cmd_v_i,
  input logic           rsp_v_i,
  input logic           req_v_i,
  input logic           req_ready_i,
  input logic           req_we_i,
  input gs_pkg::raddr_t req_addr_i,
  input gs_pkg::data_t  req_data_i,
  input gs_pkg::tag_t   req_tag_i,
  input logic           busy_i
);
  import gs_pkg::*;

  int unsigned fail_count = 0;

  // a stalled request keeps every field
  req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    req_v_i && !req_ready_i |=> req_v_i && $stable(req_we_i) && $stable(req_addr_i)
      && $stable(req_data_i) && $stable(req_tag_i))
  else begin
    $error("network request changed while stalled");
    fail_count++;
  end

  rsp_follows_cmd: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_v_i == $past(cmd_v_i))
  else begin
    $error("host response not one cycle after its command");
    fail_count++;
  end

  // busy ends right after the wake-up store is taken
  busy_end: assert property (@(posedge clk_i) disable iff (reset_i)
    $fell(busy_i) |-> $past(req_v_i && req_ready_i && req_we_i && req_data_i == data_t'(1)))
  else begin
    $error("busy fell without an accepted wake-up store");
    fail_count++;
  end

endmodule

bind gs_top gs_checker proto_chk (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .cmd_v_i     (cmd_v_i),
  .rsp_v_i     (rsp_v_o),
  .req_v_i     (req_v_o),
  .req_ready_i (req_ready_i),
  .req_we_i    (req_we_o),
  .req_addr_i  (req_addr_o),
  .req_data_i  (req_data_o),
  .req_tag_i   (req_tag_o),
  .busy_i      (busy_o)
);

/* tests/gs_tb.sv */
/*
  gather-scatter engine testbench
  directed host, gather, scatter and wake-up tests against a remote
  memory model with random ready and out-of-order returns
*/
`include "gs_config.svh"

module gs_tb;
  import gs_pkg::*;

  localparam int CLK_PERIOD  = 10;
  localparam int RESET_CYCLES = 8;
  localparam int DRIVE_DELAY = 1;
  // watchdog budget from the elements of all runs plus host traffic
  localparam int ELEMENTS        = 20 + 16 + 0 + 4;
  localparam int CYCLES_PER_ELEM = 40;
  localparam int OVERHEAD_CYCLES = 400;
  localparam int WATCHDOG_TIME   = CLK_PERIOD * (ELEMENTS * CYCLES_PER_ELEM + OVERHEAD_CYCLES);
  localparam int RUN_LIMIT       = 1000;
  localparam int MAX_PENDING     = 8;
  localparam data_t RET_MASK     = 32'h5a5a0000;

  logic   clk_i;
  logic   reset_i;
  logic   cmd_v_i;
  logic   cmd_we_i;
  haddr_t cmd_addr_i;
  data_t  cmd_data_i;
  logic   rsp_v_o;
  data_t  rsp_data_o;
  logic   req_v_o;
  logic   req_ready_i;
  logic   req_we_o;
  raddr_t req_addr_o;
  data_t  req_data_o;
  tag_t   req_tag_o;
  logic   ret_v_i;
  tag_t   ret_tag_i;
  data_t  ret_data_i;
  logic   busy_o;

  logic [15:0] lfsr_state = 16'd55;
  raddr_t      pend_addr[$];
  tag_t        pend_tag[$];
  raddr_t      store_addr[$];
  data_t       store_data[$];
  tag_t        store_tag[$];
  // reads still owed when each store was taken
  int          store_open[$];
  int          reads_seen = 0;
  int          test_errors = 0;
  int          total_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  gs_top UUT (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_v_i     (cmd_v_i),
    .cmd_we_i    (cmd_we_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_data_i  (cmd_data_i),
    .rsp_v_o     (rsp_v_o),
    .rsp_data_o  (rsp_data_o),
    .req_v_o     (req_v_o),
    .req_ready_i (req_ready_i),
    .req_we_o    (req_we_o),
    .req_addr_o  (req_addr_o),
    .req_data_o  (req_data_o),
    .req_tag_o   (req_tag_o),
    .ret_v_i     (ret_v_i),
    .ret_tag_i   (ret_tag_i),
    .ret_data_i  (ret_data_i),
    .busy_o      (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("ERROR at %0t: watchdog expired, the run did not finish", $time);
    $display("TEST FAILED");
    $finish;
  end

  // galois lfsr stepped once per random bit
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hb400;
    end else begin
      return s >> 1;
    end
  endfunction

  function automatic logic rand_bit();
    lfsr_state = lfsr_step(lfsr_state);
    return lfsr_state[0];
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int b = 0; b < n; b++) begin
      v = (v << 1) | int'(rand_bit());
    end
    return v;
  endfunction

  // remote memory samples the handshake at negedge and drives returns after posedge
  initial begin : remote_memory
    int pick;
    req_ready_i = 1'b0;
    ret_v_i     = 1'b0;
    ret_tag_i   = '0;
    ret_data_i  = '0;
    forever begin
      @(negedge clk_i);
      if (!reset_i && req_v_o && req_ready_i) begin
        if (req_we_o) begin
          store_addr.push_back(req_addr_o);
          store_data.push_back(req_data_o);
          store_tag.push_back(req_tag_o);
          store_open.push_back(pend_addr.size() + int'(ret_v_i));
        end else begin
          pend_addr.push_back(req_addr_o);
          pend_tag.push_back(req_tag_o);
          reads_seen++;
        end
      end
      @(posedge clk_i);
      #(DRIVE_DELAY);
      ret_v_i = 1'b0;
      if (pend_addr.size() > 0 && rand_bit()) begin
        pick       = rand_bits(3) % pend_addr.size();
        ret_v_i    = 1'b1;
        ret_tag_i  = pend_tag[pick];
        ret_data_i = pend_addr[pick] ^ RET_MASK;
        pend_addr.delete(pick);
        pend_tag.delete(pick);
      end
      req_ready_i = rand_bit() && (pend_addr.size() < MAX_PENDING);
    end
  end

  task automatic expect_true(input logic cond, input string what);
    assert (cond) else begin
      $display("ERROR at %0t: %s", $time, what);
      test_errors++;
    end
  endtask

  task automatic compare_word(input string name, input data_t got, input data_t exp);
    assert (got === exp) else begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("%s: passed", name);
    end else begin
      $display("%s: %0d errors", name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  function automatic haddr_t dmem_host_addr(input int i);
    return haddr_t'(`GS_DMEM_BASE + i);
  endfunction

  function automatic data_t fill_word(input int i);
    return 32'hc0de0000 ^ data_t'(i * 32'h00010003);
  endfunction

  // one host command and its response a cycle later
  task automatic send_cmd(input logic we, input haddr_t addr, input data_t data,
                          output data_t rsp);
    cmd_v_i    = 1'b1;
    cmd_we_i   = we;
    cmd_addr_i = addr;
    cmd_data_i = data;
    @(posedge clk_i);
    #(DRIVE_DELAY);
    cmd_v_i = 1'b0;
    expect_true(rsp_v_o, "no response one cycle after a host command");
    rsp = rsp_data_o;
  endtask

  task automatic write_word(input haddr_t addr, input data_t data);
    data_t rsp;
    send_cmd(1'b1, addr, data, rsp);
    compare_word("rsp_data_o after write", rsp, '0);
  endtask

  task automatic read_word(input haddr_t addr, output data_t data);
    send_cmd(1'b0, addr, '0, data);
  endtask

  task automatic configure_run(input len_t len, input raddr_t stride, input raddr_t base);
    pend_addr.delete();
    pend_tag.delete();
    store_addr.delete();
    store_data.delete();
    store_tag.delete();
    store_open.delete();
    reads_seen = 0;
    write_word(`GS_CSR_LEN, data_t'(len));
    write_word(`GS_CSR_STRIDE, stride);
    write_word(`GS_CSR_BASE, base);
  endtask

  task automatic start_run(input logic scatter, input wake_addr_t wake);
    write_word(`GS_CSR_RUN, {scatter, 13'b0, wake});
    expect_true(busy_o, "busy_o did not rise after the run command");
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy_o && n < RUN_LIMIT) begin
      @(posedge clk_i);
      #(DRIVE_DELAY);
      n++;
    end
    expect_true(!busy_o, "run did not finish, busy_o stayed high");
  endtask

  task automatic check_wakeup(input wake_addr_t wake);
    int last;
    last = store_addr.size() - 1;
    if (last < 0) begin
      expect_true(1'b0, "no wake-up store was sent");
    end else begin
      compare_word("wake req_addr_o", store_addr[last], raddr_t'(wake));
      compare_word("wake req_data_o", store_data[last], data_t'(1));
      compare_word("wake req_tag_o", data_t'(store_tag[last]), '0);
      expect_true(store_open[last] == 0, "wake-up store sent before all returns");
    end
  endtask

  task automatic host_access();
    data_t  got;
    haddr_t bad[6] = '{`GS_CSR_RUN, `GS_CSR_LEN, `GS_CSR_STRIDE, `GS_CSR_BASE,
                       12'h3ff, 12'h800};
    for (int k = 0; k < 8; k++) begin
      write_word(dmem_host_addr(k * 146 + 1), fill_word(k * 146 + 1));
    end
    for (int k = 0; k < 8; k++) begin
      read_word(dmem_host_addr(k * 146 + 1), got);
      compare_word($sformatf("dmem[%0d]", k * 146 + 1), got, fill_word(k * 146 + 1));
    end
    foreach (bad[k]) begin
      read_word(bad[k], got);
      compare_word($sformatf("read of %h", bad[k]), got, `GS_INVALID_WORD);
    end
    write_word(12'h010, 32'h12345678);
    finish_test("host access");
  endtask

  task automatic gather_run();
    data_t got;
    configure_run(11'd20, 32'd3, 32'h100);
    start_run(1'b0, 18'h01234);
    wait_idle();
    expect_true(reads_seen == 20, "gather did not issue 20 remote reads");
    expect_true(store_addr.size() == 1, "gather sent stores besides the wake-up");
    check_wakeup(18'h01234);
    for (int i = 0; i < 20; i++) begin
      read_word(dmem_host_addr(i), got);
      compare_word($sformatf("dmem[%0d]", i), got, data_t'(32'h100 + 3 * i) ^ RET_MASK);
    end
    finish_test("gather");
  endtask

  task automatic scatter_run();
    for (int i = 0; i < 16; i++) begin
      write_word(dmem_host_addr(i), fill_word(i + 1024));
    end
    configure_run(11'd16, 32'd5, 32'h2000);
    start_run(1'b1, 18'h3fffe);
    wait_idle();
    expect_true(reads_seen == 0, "scatter issued remote reads");
    if (store_addr.size() == 17) begin
      for (int i = 0; i < 16; i++) begin
        compare_word($sformatf("store %0d req_addr_o", i), store_addr[i],
                     raddr_t'(32'h2000 + 5 * i));
        compare_word($sformatf("store %0d req_data_o", i), store_data[i], fill_word(i + 1024));
      end
    end else begin
      expect_true(1'b0, "scatter did not send 16 stores and a wake-up");
    end
    check_wakeup(18'h3fffe);
    finish_test("scatter");
  endtask

  task automatic empty_run();
    configure_run(11'd0, 32'd7, 32'h50);
    start_run(1'b0, 18'h00abc);
    wait_idle();
    expect_true(reads_seen == 0 && store_addr.size() == 1, "empty run moved data");
    check_wakeup(18'h00abc);
    finish_test("empty run");
  endtask

  task automatic busy_commands();
    data_t got;
    write_word(dmem_host_addr(100), fill_word(100));
    configure_run(11'd4, 32'd1, 32'h40);
    start_run(1'b0, 18'h02222);
    read_word(dmem_host_addr(100), got);
    compare_word("rsp_data_o during run", got, `GS_INVALID_WORD);
    expect_true(busy_o, "run ended before the write during the run");
    write_word(dmem_host_addr(100), 32'h0bad0bad);
    wait_idle();
    check_wakeup(18'h02222);
    read_word(dmem_host_addr(100), got);
    compare_word("dmem[100]", got, fill_word(100));
    finish_test("commands while busy");
  endtask

  initial begin
    reset_i    = 1'b1;
    cmd_v_i    = 1'b0;
    cmd_we_i   = 1'b0;
    cmd_addr_i = '0;
    cmd_data_i = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #(DRIVE_DELAY);
    reset_i = 1'b0;
    host_access();
    gather_run();
    scatter_run();
    empty_run();
    busy_commands();
    $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
             tests_run, tests_failed, total_errors, UUT.proto_chk.fail_count);
    if (total_errors == 0 && UUT.proto_chk.fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* tb.f */
+incdir+design
design/gs_pkg.sv
design/gs_if.sv
design/gs_host_port.sv
design/gs_sequencer.sv
design/gs_scoreboard.sv
design/gs_dmem.sv
design/gs_top.sv
tests/gs_checker.sv
tests/gs_tb.sv

/* run.sh */
#!/bin/sh
# build the gather-scatter testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module gs_tb -f tb.f -o gs_sim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/gs_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -qx "TEST OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
